/* adder_params.svh */
// adder cluster parameters

`ifndef ADDER_PARAMS_SVH
`define ADDER_PARAMS_SVH

// issue buffer slots
`define ADDER_ISSUE_DEPTH 4

// slot index width, log2 of the depth
`define ADDER_ISSUE_IDX_W 2

// architectural integer registers
`define XREG_NUM 32

// register and datapath width
`define XLEN 64

`endif

/* adder_pkg.sv */
// adder cluster types

`default_nettype none

`include "adder_params.svh"

package adder_pkg;

	// adder opcodes
	typedef enum logic [2:0] {
		OP_LUI   = 3'd0,
		OP_AUIPC = 3'd1,
		OP_ADDI  = 3'd2,
		OP_ADDIW = 3'd3,
		OP_ADD   = 3'd4,
		OP_ADDW  = 3'd5,
		OP_SUB   = 3'd6,
		OP_SUBW  = 3'd7
	} adder_op_e;

	// one dispatched entry, imm already sign-extended
	typedef struct packed {
		adder_op_e op;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] imm;
		logic [$clog2(`XREG_NUM)-1:0] rd;
		logic [$clog2(`XREG_NUM)-1:0] rs1;
		logic [$clog2(`XREG_NUM)-1:0] rs2;
	} adder_issue_info_t;

	// operands handed to execute
	typedef struct packed {
		logic is_sub;
		logic is32;
		logic [$clog2(`XREG_NUM)-1:0] rd;
		logic [`XLEN-1:0] op1;
		logic [`XLEN-1:0] op2;
	} adder_exeparam_t;

	typedef struct packed {
		logic valid;
		logic [$clog2(`XREG_NUM)-1:0] rd;
		logic [`XLEN-1:0] data;
	} xreg_wb_t;

	// marks rd pending
	typedef struct packed {
		logic valid;
		logic [$clog2(`XREG_NUM)-1:0] rd;
	} xreg_alloc_t;

endpackage

`default_nettype wire

/* phy_regfile.sv */
// integer register file with ready log

`timescale 1ns/10ps
`default_nettype none

`include "adder_params.svh"

module phy_regfile (
	input wire CLK,
	input wire rst,

	input wire adder_pkg::xreg_alloc_t disp_alloc,
	input wire adder_pkg::xreg_alloc_t ext_alloc,
	input wire adder_pkg::xreg_wb_t adder_wb,
	input wire adder_pkg::xreg_wb_t ext_wb,

	output logic [`XREG_NUM*`XLEN-1:0] xreg_read,
	output logic [`XREG_NUM-1:0] wb_log
);

	// x0 has no storage
	logic [`XLEN-1:0] xreg [1:`XREG_NUM-1];
	logic [`XREG_NUM-1:1] ready;

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 1; i < `XREG_NUM; i++) begin
				xreg[i] <= '0;
			end
			ready <= '1;
		end else begin
			for (int i = 1; i < `XREG_NUM; i++) begin
				// writes beat allocation, ext port beats adder
				if (ext_wb.valid && ext_wb.rd == i) begin
					xreg[i] <= ext_wb.data;
					ready[i] <= 1'b1;
				end else if (adder_wb.valid && adder_wb.rd == i) begin
					xreg[i] <= adder_wb.data;
					ready[i] <= 1'b1;
				end else if ((disp_alloc.valid && disp_alloc.rd == i) ||
						(ext_alloc.valid && ext_alloc.rd == i)) begin
					ready[i] <= 1'b0;
				end
			end
		end
	end

	assign xreg_read[`XLEN-1:0] = '0;

	generate
		for (genvar i = 1; i < `XREG_NUM; i++) begin : g_read
			assign xreg_read[i*`XLEN +: `XLEN] = xreg[i];
		end
	endgenerate

	assign wb_log = {ready, 1'b1};

endmodule

`default_nettype wire

/* adder_issue_buffer.sv */
// adder issue buffer

`timescale 1ns/10ps
`default_nettype none

`include "adder_params.svh"

module adder_issue_buffer (
	input wire CLK,
	input wire rst,

	input wire disp_valid,
	output logic disp_ready,
	input wire adder_pkg::adder_issue_info_t disp_info,

	input wire buffer_pop,
	input wire [`ADDER_ISSUE_IDX_W-1:0] pop_index,

	output logic [`ADDER_ISSUE_DEPTH-1:0] buffer_malloc,
	output adder_pkg::adder_issue_info_t [`ADDER_ISSUE_DEPTH-1:0] issue_info,
	output adder_pkg::xreg_alloc_t disp_alloc
);

	logic [`ADDER_ISSUE_IDX_W-1:0] free_idx;
	logic any_free;
	logic push;
	logic [`ADDER_ISSUE_DEPTH-1:0] push_mask;
	logic [`ADDER_ISSUE_DEPTH-1:0] pop_mask;

	// lowest free slot
	always_comb begin
		free_idx = '0;
		any_free = 1'b0;
		for (int i = `ADDER_ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (!buffer_malloc[i]) begin
				free_idx = i[`ADDER_ISSUE_IDX_W-1:0];
				any_free = 1'b1;
			end
		end
	end

	assign disp_ready = any_free;
	assign push = disp_valid & disp_ready;

	assign push_mask = push ? (`ADDER_ISSUE_DEPTH'(1) << free_idx) : '0;
	assign pop_mask = buffer_pop ? (`ADDER_ISSUE_DEPTH'(1) << pop_index) : '0;

	always_ff @(posedge CLK) begin
		if (rst) begin
			buffer_malloc <= '0;
		end else begin
			buffer_malloc <= (buffer_malloc & ~pop_mask) | push_mask;
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			issue_info[free_idx] <= disp_info;
		end
	end

	// destination goes pending on the push edge
	assign disp_alloc.valid = push;
	assign disp_alloc.rd = disp_info.rd;

endmodule

`default_nettype wire

/* adder_issue.sv */
// adder issue stage

`timescale 1ns/10ps
`default_nettype none

`include "adder_params.svh"

module adder_issue (
	input wire CLK,
	input wire rst,

	input wire [`ADDER_ISSUE_DEPTH-1:0] buffer_malloc,
	input wire adder_pkg::adder_issue_info_t [`ADDER_ISSUE_DEPTH-1:0] issue_info,

	input wire [`XREG_NUM*`XLEN-1:0] xreg_read,
	input wire [`XREG_NUM-1:0] wb_log,

	output logic buffer_pop,
	output logic [`ADDER_ISSUE_IDX_W-1:0] pop_index,

	output logic exeparam_valid,
	output adder_pkg::adder_exeparam_t exeparam
);

	logic [`ADDER_ISSUE_DEPTH-1:0] clear_raw;
	adder_pkg::adder_exeparam_t [`ADDER_ISSUE_DEPTH-1:0] cand;
	logic pick_valid;
	logic [`ADDER_ISSUE_IDX_W-1:0] pick_idx;

	generate
		for (genvar i = 0; i < `ADDER_ISSUE_DEPTH; i++) begin : g_slot
			adder_pkg::adder_issue_info_t info;
			adder_pkg::adder_exeparam_t param;
			logic [`XLEN-1:0] src1;
			logic [`XLEN-1:0] src2;
			logic rs1_rdy;
			logic rs2_rdy;
			logic clear;

			assign info = issue_info[i];
			assign src1 = xreg_read[info.rs1*`XLEN +: `XLEN];
			assign src2 = xreg_read[info.rs2*`XLEN +: `XLEN];
			assign rs1_rdy = wb_log[info.rs1];
			assign rs2_rdy = wb_log[info.rs2];

			// register-register add by default
			always_comb begin
				param.is_sub = 1'b0;
				param.is32 = 1'b0;
				param.rd = info.rd;
				param.op1 = src1;
				param.op2 = src2;
				clear = rs1_rdy & rs2_rdy;
				case (info.op)
					adder_pkg::OP_LUI: begin
						param.op1 = '0;
						param.op2 = info.imm;
						clear = 1'b1;
					end
					adder_pkg::OP_AUIPC: begin
						param.op1 = info.pc;
						param.op2 = info.imm;
						clear = 1'b1;
					end
					adder_pkg::OP_ADDI: begin
						param.op2 = info.imm;
						clear = rs1_rdy;
					end
					adder_pkg::OP_ADDIW: begin
						param.op2 = info.imm;
						param.is32 = 1'b1;
						clear = rs1_rdy;
					end
					adder_pkg::OP_ADDW: param.is32 = 1'b1;
					adder_pkg::OP_SUB: param.is_sub = 1'b1;
					adder_pkg::OP_SUBW: begin
						param.is_sub = 1'b1;
						param.is32 = 1'b1;
					end
					default: ;
				endcase
			end

			assign cand[i] = param;
			assign clear_raw[i] = buffer_malloc[i] & clear;
		end
	endgenerate

	// lowest clear slot wins
	always_comb begin
		pick_valid = 1'b0;
		pick_idx = '0;
		for (int i = `ADDER_ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				pick_valid = 1'b1;
				pick_idx = i[`ADDER_ISSUE_IDX_W-1:0];
			end
		end
	end

	// adder never stalls, so a pick always pops
	assign buffer_pop = pick_valid;
	assign pop_index = pick_idx;

	always_ff @(posedge CLK) begin
		if (rst) begin
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= pick_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (pick_valid) begin
			exeparam <= cand[pick_idx];
		end
	end

endmodule

`default_nettype wire

/* adder_execute.sv */
// adder execute unit

`timescale 1ns/10ps
`default_nettype none

`include "adder_params.svh"

module adder_execute (
	input wire CLK,
	input wire rst,

	input wire exeparam_valid,
	input wire adder_pkg::adder_exeparam_t exeparam,

	output adder_pkg::xreg_wb_t adder_wb
);

	logic [`XLEN-1:0] sum;
	logic [`XLEN-1:0] result;
	logic wb_valid;
	logic [$clog2(`XREG_NUM)-1:0] wb_rd;
	logic [`XLEN-1:0] wb_data;

	assign sum = exeparam.is_sub ? exeparam.op1 - exeparam.op2 : exeparam.op1 + exeparam.op2;

	// W forms keep the low word, sign-extended
	assign result = exeparam.is32 ? {{(`XLEN - 32){sum[31]}}, sum[31:0]} : sum;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exeparam_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			wb_rd <= exeparam.rd;
			wb_data <= result;
		end
	end

	assign adder_wb.valid = wb_valid;
	assign adder_wb.rd = wb_rd;
	assign adder_wb.data = wb_data;

endmodule

`default_nettype wire

/* adder_cluster_top.sv */
// adder cluster top

`timescale 1ns/10ps
`default_nettype none

`include "adder_params.svh"

module adder_cluster_top (
	input wire CLK,
	input wire rst,

	input wire disp_valid,
	output logic disp_ready,
	input wire adder_pkg::adder_issue_info_t disp_info,

	input wire adder_pkg::xreg_alloc_t ext_alloc,
	input wire adder_pkg::xreg_wb_t ext_wb,

	output adder_pkg::xreg_wb_t adder_wb
);

	adder_pkg::xreg_alloc_t disp_alloc;
	logic [`ADDER_ISSUE_DEPTH-1:0] buffer_malloc;
	adder_pkg::adder_issue_info_t [`ADDER_ISSUE_DEPTH-1:0] issue_info;
	logic buffer_pop;
	logic [`ADDER_ISSUE_IDX_W-1:0] pop_index;
	logic [`XREG_NUM*`XLEN-1:0] xreg_read;
	logic [`XREG_NUM-1:0] wb_log;
	logic exeparam_valid;
	adder_pkg::adder_exeparam_t exeparam;

	phy_regfile regfile_i (
		.CLK(CLK),
		.rst(rst),
		.disp_alloc(disp_alloc),
		.ext_alloc(ext_alloc),
		.adder_wb(adder_wb),
		.ext_wb(ext_wb),
		.xreg_read(xreg_read),
		.wb_log(wb_log)
	);

	adder_issue_buffer buffer_i (
		.CLK(CLK),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp_info(disp_info),
		.buffer_pop(buffer_pop),
		.pop_index(pop_index),
		.buffer_malloc(buffer_malloc),
		.issue_info(issue_info),
		.disp_alloc(disp_alloc)
	);

	adder_issue issue_i (
		.CLK(CLK),
		.rst(rst),
		.buffer_malloc(buffer_malloc),
		.issue_info(issue_info),
		.xreg_read(xreg_read),
		.wb_log(wb_log),
		.buffer_pop(buffer_pop),
		.pop_index(pop_index),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam)
	);

	adder_execute execute_i (
		.CLK(CLK),
		.rst(rst),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam),
		.adder_wb(adder_wb)
	);

endmodule

`default_nettype wire

/* adder_tb.sv */
// adder cluster testbench

`timescale 1ns/10ps
`default_nettype none

`include "adder_params.svh"

module adder_tb;

	localparam int NROWS = 17;
	localparam int TIMEOUT = 200;
	localparam logic [1:0] REL_NONE = 2'd0;
	localparam logic [1:0] REL_AFTER_WB = 2'd1;
	localparam logic [1:0] REL_ON_STALL = 2'd2;

	// one instruction plus the external register it releases
	typedef struct packed {
		adder_pkg::adder_issue_info_t info;
		logic [1:0] rel_mode;
		logic [4:0] rel_reg;
		logic [`XLEN-1:0] rel_data;
	} row_t;

	logic CLK = 1'b0;
	logic rst;
	logic disp_valid;
	logic disp_ready;
	adder_pkg::adder_issue_info_t disp_info;
	adder_pkg::xreg_alloc_t ext_alloc;
	adder_pkg::xreg_wb_t ext_wb;
	adder_pkg::xreg_wb_t adder_wb;

	row_t rows [NROWS];
	logic [`XLEN-1:0] mregs [`XREG_NUM];
	logic [`XREG_NUM-1:0] pending;
	logic [NROWS-1:0] dispatched;
	logic [NROWS-1:0] done;
	int wb_count;

	adder_cluster_top dut_i (
		.CLK(CLK),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp_info(disp_info),
		.ext_alloc(ext_alloc),
		.ext_wb(ext_wb),
		.adder_wb(adder_wb)
	);

	always #4 CLK = ~CLK;

	function automatic row_t make_row(adder_pkg::adder_op_e op, logic [63:0] pc,
			logic [63:0] imm, int rd, int rs1, int rs2);
		row_t r;
		r = '0;
		r.info.op = op;
		r.info.pc = pc;
		r.info.imm = imm;
		r.info.rd = 5'(rd);
		r.info.rs1 = 5'(rs1);
		r.info.rs2 = 5'(rs2);
		r.rel_mode = REL_NONE;
		return r;
	endfunction

	// LUI and AUIPC read nothing, immediate forms read rs1 only
	function automatic logic sources_pending(int n);
		adder_pkg::adder_issue_info_t i;
		i = rows[n].info;
		if (i.op inside {adder_pkg::OP_LUI, adder_pkg::OP_AUIPC}) begin
			return 1'b0;
		end
		if (i.op inside {adder_pkg::OP_ADDI, adder_pkg::OP_ADDIW}) begin
			return pending[i.rs1];
		end
		return pending[i.rs1] | pending[i.rs2];
	endfunction

	function automatic logic [63:0] expected_result(int n);
		adder_pkg::adder_issue_info_t i;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] r;
		i = rows[n].info;
		a = mregs[i.rs1];
		b = mregs[i.rs2];
		if (i.op == adder_pkg::OP_LUI) begin
			a = '0;
		end else if (i.op == adder_pkg::OP_AUIPC) begin
			a = i.pc;
		end
		if (i.op inside {adder_pkg::OP_LUI, adder_pkg::OP_AUIPC, adder_pkg::OP_ADDI,
				adder_pkg::OP_ADDIW}) begin
			b = i.imm;
		end
		r = (i.op inside {adder_pkg::OP_SUB, adder_pkg::OP_SUBW}) ? a - b : a + b;
		if (i.op inside {adder_pkg::OP_ADDIW, adder_pkg::OP_ADDW, adder_pkg::OP_SUBW}) begin
			r = {{32{r[31]}}, r[31:0]};
		end
		return r;
	endfunction

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// destinations are unique, so rd identifies the entry
	task automatic collect_writeback();
		int n;
		logic [63:0] exp;
		n = -1;
		if (adder_wb.valid === 1'b1) begin
			for (int i = 0; i < NROWS; i++) begin
				if (dispatched[i] && !done[i] && rows[i].info.rd == adder_wb.rd) begin
					n = i;
				end
			end
			if (n < 0) begin
				stop_with_failure($sformatf("writeback to x%0d matches no waiting entry",
					adder_wb.rd));
			end else if (sources_pending(n)) begin
				stop_with_failure($sformatf("entry %0d wrote back before its sources were ready",
					n));
			end else begin
				exp = expected_result(n);
				check_value($sformatf("adder_wb.data x%0d", adder_wb.rd), adder_wb.data, exp);
				mregs[adder_wb.rd] = exp;
				pending[adder_wb.rd] = 1'b0;
				done[n] = 1'b1;
				wb_count++;
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge CLK);
		collect_writeback();
	endtask

	task automatic write_ext(int r, logic [63:0] d);
		ext_wb.valid = 1'b1;
		ext_wb.rd = 5'(r);
		ext_wb.data = d;
		mregs[r] = d;
		pending[r] = 1'b0;
		next_cycle();
		ext_wb.valid = 1'b0;
	endtask

	task automatic hold_ext(int r);
		ext_alloc.valid = 1'b1;
		ext_alloc.rd = 5'(r);
		pending[r] = 1'b1;
		next_cycle();
		ext_alloc.valid = 1'b0;
	endtask

	task automatic dispatch(int n);
		int waited;
		disp_info = rows[n].info;
		disp_valid = 1'b1;
		if (rows[n].rel_mode == REL_ON_STALL) begin
			// buffer full of blocked entries
			repeat (4) begin
				check_value("disp_ready", 64'(disp_ready), '0);
				next_cycle();
			end
			write_ext(rows[n].rel_reg, rows[n].rel_data);
		end
		waited = 0;
		while (disp_ready !== 1'b1) begin
			if (waited == TIMEOUT) begin
				stop_with_failure($sformatf("dispatch of entry %0d was never accepted", n));
			end
			next_cycle();
			waited++;
		end
		pending[rows[n].info.rd] = 1'b1;
		dispatched[n] = 1'b1;
		next_cycle();
		disp_valid = 1'b0;
	endtask

	task automatic wait_for_writeback(int n);
		int waited;
		waited = 0;
		while (!done[n]) begin
			if (waited == TIMEOUT) begin
				stop_with_failure($sformatf("entry %0d never wrote back", n));
			end
			next_cycle();
			waited++;
		end
	endtask

	// x20 and x21 are held pending from outside the cluster
	task automatic fill_rows();
		rows[0] = make_row(adder_pkg::OP_ADDI, 64'h0, 64'h0, 9, 1, 0);
		rows[1] = make_row(adder_pkg::OP_ADDI, 64'h0, 64'h0, 10, 2, 0);
		rows[2] = make_row(adder_pkg::OP_ADDW, 64'h0, 64'h0, 11, 3, 4);
		rows[3] = make_row(adder_pkg::OP_SUB, 64'h0, 64'h0, 12, 4, 5);
		rows[4] = make_row(adder_pkg::OP_SUBW, 64'h0, 64'h0, 13, 1, 2);
		rows[5] = make_row(adder_pkg::OP_ADDIW, 64'h0, 64'h1, 14, 3, 0);
		rows[6] = make_row(adder_pkg::OP_LUI, 64'h0, 64'hffff_ffff_8765_4000, 15, 20, 21);
		rows[7] = make_row(adder_pkg::OP_AUIPC, 64'h8000_1000, 64'h1234_5000, 16, 21, 20);
		rows[8] = make_row(adder_pkg::OP_ADD, 64'h0, 64'h0, 17, 0, 6);
		rows[9] = make_row(adder_pkg::OP_ADD, 64'h0, 64'h0, 18, 9, 11);
		rows[10] = make_row(adder_pkg::OP_ADD, 64'h0, 64'h0, 19, 20, 1);
		rows[11] = make_row(adder_pkg::OP_ADDI, 64'h0, 64'h5, 22, 7, 0);
		rows[12] = make_row(adder_pkg::OP_ADD, 64'h0, 64'h0, 23, 21, 1);
		rows[13] = make_row(adder_pkg::OP_SUB, 64'h0, 64'h0, 24, 2, 21);
		rows[14] = make_row(adder_pkg::OP_ADDW, 64'h0, 64'h0, 25, 21, 21);
		rows[15] = make_row(adder_pkg::OP_ADDI, 64'h0, 64'hffff_ffff_ffff_ffff, 26, 21, 0);
		rows[16] = make_row(adder_pkg::OP_SUBW, 64'h0, 64'h0, 27, 21, 8);
		rows[11].rel_mode = REL_AFTER_WB;
		rows[11].rel_reg = 5'd20;
		rows[11].rel_data = {$urandom, $urandom};
		rows[16].rel_mode = REL_ON_STALL;
		rows[16].rel_reg = 5'd21;
		rows[16].rel_data = 64'h0000_0000_8000_0000;
	endtask

	initial begin
		int waited;
		void'($urandom(32'h04e0_a8c4));
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_info = '0;
		ext_alloc = '0;
		ext_wb = '0;
		for (int r = 0; r < `XREG_NUM; r++) begin
			mregs[r] = '0;
		end
		pending = '0;
		dispatched = '0;
		done = '0;
		wb_count = 0;
		fill_rows();
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		next_cycle();
		check_value("adder_wb.valid", 64'(adder_wb.valid), '0);
		check_value("disp_ready", 64'(disp_ready), 64'h1);

		// x3..x5 fixed for the W-form overflow and SUB underflow cases
		write_ext(1, {$urandom, $urandom});
		write_ext(2, {$urandom, $urandom});
		write_ext(3, 64'h0000_0000_7fff_ffff);
		write_ext(4, 64'h1);
		write_ext(5, 64'h2);
		write_ext(6, {$urandom, $urandom});
		write_ext(7, {$urandom, $urandom});
		write_ext(8, {$urandom, $urandom});
		hold_ext(20);
		hold_ext(21);

		for (int n = 0; n < NROWS; n++) begin
			dispatch(n);
			// older blocked entry released only once the younger one is back
			if (rows[n].rel_mode == REL_AFTER_WB) begin
				wait_for_writeback(n);
				write_ext(rows[n].rel_reg, rows[n].rel_data);
			end
		end

		waited = 0;
		while (wb_count < NROWS) begin
			if (waited == TIMEOUT) begin
				stop_with_failure($sformatf("only %0d of %0d writebacks arrived", wb_count, NROWS));
			end
			next_cycle();
			waited++;
		end
		// stray writebacks would show up here
		repeat (8) next_cycle();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
adder_pkg.sv
phy_regfile.sv
adder_issue_buffer.sv
adder_issue.sv
adder_execute.sv
adder_cluster_top.sv
adder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= adder_tb
LINT_TOP ?= adder_cluster_top
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only if the testbench printed the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
